/* rtl/dualIssuePkg.sv */
package dualIssuePkg;

    localparam int NumRegs  = 32;   // Architectural integer registers
    localparam int RegAddrW = 5;    // Register address width

    // ALU opcodes, shared by both lanes
    typedef enum logic [3:0] {
        OpAdd = 4'd0,
        OpSub = 4'd1,
        OpAnd = 4'd2,
        OpOr  = 4'd3,
        OpXor = 4'd4,
        OpSll = 4'd5,
        OpSrl = 4'd6,
        OpSlt = 4'd7,   // Signed compare
        OpMul = 4'd8    // Lane B only, product formed in MEM
    } aluOpE;

    // Source of the write-back value in lane B
    typedef enum logic {
        WbAlu = 1'b0,   // ALU result, forwardable from MEM
        WbMul = 1'b1    // Multiplier product, WB and later only
    } wbSelE;

endpackage

/* rtl/bypassIf.sv */
`timescale 1ns/1ps

interface bypassIf #(
    parameter int XLEN = 32
);

    logic                               memWeA;     // MEM stage, lane A
    logic                               memWeB;
    logic [dualIssuePkg::RegAddrW-1:0]  memAddrA;
    logic [dualIssuePkg::RegAddrW-1:0]  memAddrB;
    logic [XLEN-1:0]                    memAluA;
    logic [XLEN-1:0]                    memAluB;
    dualIssuePkg::wbSelE                memSelB;    // Gates MEM-B forwarding

    logic                               wbWeA;      // WB stage, final data
    logic                               wbWeB;
    logic [dualIssuePkg::RegAddrW-1:0]  wbAddrA;
    logic [dualIssuePkg::RegAddrW-1:0]  wbAddrB;
    logic [XLEN-1:0]                    wbDataA;
    logic [XLEN-1:0]                    wbDataB;

    modport source (
        output memWeA, memWeB, memAddrA, memAddrB, memAluA, memAluB, memSelB,
        output wbWeA, wbWeB, wbAddrA, wbAddrB, wbDataA, wbDataB
    );

    modport sink (
        input memWeA, memWeB, memAddrA, memAddrB, memAluA, memAluB, memSelB,
        input wbWeA, wbWeB, wbAddrA, wbAddrB, wbDataA, wbDataB
    );

endinterface

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic [dualIssuePkg::RegAddrW-1:0] raddrA1,
    input  logic [dualIssuePkg::RegAddrW-1:0] raddrA2,
    input  logic [dualIssuePkg::RegAddrW-1:0] raddrB1,
    input  logic [dualIssuePkg::RegAddrW-1:0] raddrB2,
    input  logic                              weA,
    input  logic                              weB,
    input  logic [dualIssuePkg::RegAddrW-1:0] waddrA,
    input  logic [dualIssuePkg::RegAddrW-1:0] waddrB,
    input  logic [XLEN-1:0]                   wdataA,
    input  logic [XLEN-1:0]                   wdataB,
    output logic [XLEN-1:0]                   rdataA1,
    output logic [XLEN-1:0]                   rdataA2,
    output logic [XLEN-1:0]                   rdataB1,
    output logic [XLEN-1:0]                   rdataB2
);

    logic [XLEN-1:0] regs [1:dualIssuePkg::NumRegs-1];  // No storage for x0

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < dualIssuePkg::NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (weA) begin
                regs[waddrA] <= wdataA;
            end
            if (weB) begin
                regs[waddrB] <= wdataB;     // Younger lane overrides A
            end
        end
    end

    // Asynchronous reads, x0 hard-wired
    assign rdataA1 = (raddrA1 == '0) ? '0 : regs[raddrA1];
    assign rdataA2 = (raddrA2 == '0) ? '0 : regs[raddrA2];
    assign rdataB1 = (raddrB1 == '0) ? '0 : regs[raddrB1];
    assign rdataB2 = (raddrB2 == '0) ? '0 : regs[raddrB2];

endmodule

/* rtl/forwardUnit.sv */
`timescale 1ns/1ps

module forwardUnit #(
    parameter int XLEN = 32
) (
    bypassIf.sink                             byp,
    input  logic [dualIssuePkg::RegAddrW-1:0] raddrA1,
    input  logic [dualIssuePkg::RegAddrW-1:0] raddrA2,
    input  logic [dualIssuePkg::RegAddrW-1:0] raddrB1,
    input  logic [dualIssuePkg::RegAddrW-1:0] raddrB2,
    input  logic [XLEN-1:0]                   rdataA1,  // Register file values
    input  logic [XLEN-1:0]                   rdataA2,
    input  logic [XLEN-1:0]                   rdataB1,
    input  logic [XLEN-1:0]                   rdataB2,
    output logic [XLEN-1:0]                   opA1,     // Forwarded operands
    output logic [XLEN-1:0]                   opA2,
    output logic [XLEN-1:0]                   opB1,
    output logic [XLEN-1:0]                   opB2
);

    // Enables are already cleared for x0 destinations, so no zero check here.
    // Newest producer first: MEM-B, MEM-A, WB-B, WB-A, then the register file.
    function automatic logic [XLEN-1:0] pickOperand(
        input logic [dualIssuePkg::RegAddrW-1:0] raddr,
        input logic [XLEN-1:0]                   rfVal
    );
        logic memHitB;
        logic memHitA;
        logic wbHitB;
        logic wbHitA;
        memHitB = byp.memWeB && (byp.memAddrB == raddr)
                  && (byp.memSelB == dualIssuePkg::WbAlu);   // Products skip MEM
        memHitA = byp.memWeA && (byp.memAddrA == raddr);
        wbHitB  = byp.wbWeB && (byp.wbAddrB == raddr);
        wbHitA  = byp.wbWeA && (byp.wbAddrA == raddr);
        if (memHitB) begin
            pickOperand = byp.memAluB;
        end else if (memHitA) begin
            pickOperand = byp.memAluA;
        end else if (wbHitB) begin
            pickOperand = byp.wbDataB;
        end else if (wbHitA) begin
            pickOperand = byp.wbDataA;
        end else begin
            pickOperand = rfVal;
        end
    endfunction

    // Four independent selectors
    always_comb begin
        opA1 = pickOperand(raddrA1, rdataA1);
        opA2 = pickOperand(raddrA2, rdataA2);
        opB1 = pickOperand(raddrB1, rdataB1);
        opB2 = pickOperand(raddrB2, rdataB2);
    end

endmodule

/* rtl/intAlu.sv */
`timescale 1ns/1ps

module intAlu #(
    parameter int XLEN = 32
) (
    input  dualIssuePkg::aluOpE op,
    input  logic [XLEN-1:0]     srcA,
    input  logic [XLEN-1:0]     srcB,
    output logic [XLEN-1:0]     result
);

    localparam int ShW = $clog2(XLEN);     // 5 bits at 32, 6 at 64

    logic [ShW-1:0] shamt;
    logic           lessThan;

    assign shamt    = srcB[ShW-1:0];
    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (op)
            dualIssuePkg::OpAdd: result = srcA + srcB;
            dualIssuePkg::OpSub: result = srcA - srcB;
            dualIssuePkg::OpAnd: result = srcA & srcB;
            dualIssuePkg::OpOr:  result = srcA | srcB;
            dualIssuePkg::OpXor: result = srcA ^ srcB;
            dualIssuePkg::OpSll: result = srcA << shamt;
            dualIssuePkg::OpSrl: result = srcA >> shamt;    // Logical shift
            dualIssuePkg::OpSlt: result = {{(XLEN-1){1'b0}}, lessThan};
            default:             result = '0;   // OpMul, product comes from MEM
        endcase
    end

endmodule

/* rtl/backendPipe.sv */
`timescale 1ns/1ps

module backendPipe #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              validA,   // Issue, lane A (older)
    input  dualIssuePkg::aluOpE               opA,
    input  logic [dualIssuePkg::RegAddrW-1:0] rdA,
    input  logic [dualIssuePkg::RegAddrW-1:0] rs1A,
    input  logic [dualIssuePkg::RegAddrW-1:0] rs2A,
    input  logic                              validB,   // Issue, lane B
    input  dualIssuePkg::aluOpE               opB,
    input  logic [dualIssuePkg::RegAddrW-1:0] rdB,
    input  logic [dualIssuePkg::RegAddrW-1:0] rs1B,
    input  logic [dualIssuePkg::RegAddrW-1:0] rs2B,
    input  logic [XLEN-1:0]                   aluResA,
    input  logic [XLEN-1:0]                   aluResB,
    input  logic [XLEN-1:0]                   mulSrc1,  // Forwarded lane B operands
    input  logic [XLEN-1:0]                   mulSrc2,
    output dualIssuePkg::aluOpE               exOpA,
    output dualIssuePkg::aluOpE               exOpB,
    output logic [dualIssuePkg::RegAddrW-1:0] exRsA1,
    output logic [dualIssuePkg::RegAddrW-1:0] exRsA2,
    output logic [dualIssuePkg::RegAddrW-1:0] exRsB1,
    output logic [dualIssuePkg::RegAddrW-1:0] exRsB2,
    output logic                              wbEnA,
    output logic [dualIssuePkg::RegAddrW-1:0] wbAddrA,
    output logic [XLEN-1:0]                   wbDataA,
    output logic                              wbEnB,
    output logic [dualIssuePkg::RegAddrW-1:0] wbAddrB,
    output logic [XLEN-1:0]                   wbDataB,
    bypassIf.source                           byp
);

    logic                              exWeA, exWeB;
    logic [dualIssuePkg::RegAddrW-1:0] exRdA, exRdB;
    logic                              memWeA, memWeB;
    logic [dualIssuePkg::RegAddrW-1:0] memRdA, memRdB;
    logic [XLEN-1:0]                   memAluA, memAluB;
    logic [XLEN-1:0]                   mulOp1, mulOp2;     // Latched at end of EX
    logic [XLEN-1:0]                   mulProd;
    dualIssuePkg::wbSelE               memSelB;

    // Enables and valids
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exWeA  <= 1'b0;
            exWeB  <= 1'b0;
            memWeA <= 1'b0;
            memWeB <= 1'b0;
            wbEnA  <= 1'b0;
            wbEnB  <= 1'b0;
        end else begin
            exWeA  <= validA && (rdA != '0);    // x0 writes dropped here
            exWeB  <= validB && (rdB != '0);
            memWeA <= exWeA;
            memWeB <= exWeB;
            wbEnA  <= memWeA;
            wbEnB  <= memWeB;
        end
    end

    // Payload, EX -> MEM -> WB
    always_ff @(posedge clk) begin
        exOpA   <= opA;
        exOpB   <= opB;
        exRdA   <= rdA;
        exRdB   <= rdB;
        exRsA1  <= rs1A;
        exRsA2  <= rs2A;
        exRsB1  <= rs1B;
        exRsB2  <= rs2B;
        memRdA  <= exRdA;
        memRdB  <= exRdB;
        memAluA <= aluResA;
        memAluB <= aluResB;
        mulOp1  <= mulSrc1;
        mulOp2  <= mulSrc2;
        memSelB <= (exOpB == dualIssuePkg::OpMul) ? dualIssuePkg::WbMul : dualIssuePkg::WbAlu;
        wbAddrA <= memRdA;
        wbAddrB <= memRdB;
        wbDataA <= memAluA;
        wbDataB <= (memSelB == dualIssuePkg::WbMul) ? mulProd : memAluB;
    end

    assign mulProd = mulOp1 * mulOp2;   // Low XLEN bits

    assign byp.memWeA   = memWeA;
    assign byp.memWeB   = memWeB;
    assign byp.memAddrA = memRdA;
    assign byp.memAddrB = memRdB;
    assign byp.memAluA  = memAluA;
    assign byp.memAluB  = memAluB;
    assign byp.memSelB  = memSelB;
    assign byp.wbWeA    = wbEnA;
    assign byp.wbWeB    = wbEnB;
    assign byp.wbAddrA  = wbAddrA;
    assign byp.wbAddrB  = wbAddrB;
    assign byp.wbDataA  = wbDataA;
    assign byp.wbDataB  = wbDataB;

endmodule

/* rtl/dualExecTop.sv */
`timescale 1ns/1ps

module dualExecTop #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              validA,
    input  dualIssuePkg::aluOpE               opA,
    input  logic [dualIssuePkg::RegAddrW-1:0] rdA,
    input  logic [dualIssuePkg::RegAddrW-1:0] rs1A,
    input  logic [dualIssuePkg::RegAddrW-1:0] rs2A,
    input  logic                              validB,
    input  dualIssuePkg::aluOpE               opB,
    input  logic [dualIssuePkg::RegAddrW-1:0] rdB,
    input  logic [dualIssuePkg::RegAddrW-1:0] rs1B,
    input  logic [dualIssuePkg::RegAddrW-1:0] rs2B,
    output logic                              wbEnA,
    output logic [dualIssuePkg::RegAddrW-1:0] wbAddrA,
    output logic [XLEN-1:0]                   wbDataA,
    output logic                              wbEnB,
    output logic [dualIssuePkg::RegAddrW-1:0] wbAddrB,
    output logic [XLEN-1:0]                   wbDataB
);

    dualIssuePkg::aluOpE               exOpA, exOpB;
    logic [dualIssuePkg::RegAddrW-1:0] exRsA1, exRsA2, exRsB1, exRsB2;
    logic [XLEN-1:0]                   rdataA1, rdataA2, rdataB1, rdataB2;
    logic [XLEN-1:0]                   opA1, opA2, opB1, opB2;   // After forwarding
    logic [XLEN-1:0]                   aluResA, aluResB;

    bypassIf #(.XLEN(XLEN)) iByp ();

    backendPipe #(.XLEN(XLEN)) iPipe (
        .clk, .rstN,
        .validA, .opA, .rdA, .rs1A, .rs2A,
        .validB, .opB, .rdB, .rs1B, .rs2B,
        .aluResA, .aluResB,
        .mulSrc1(opB1), .mulSrc2(opB2),
        .exOpA, .exOpB, .exRsA1, .exRsA2, .exRsB1, .exRsB2,
        .wbEnA, .wbAddrA, .wbDataA, .wbEnB, .wbAddrB, .wbDataB,
        .byp(iByp.source)
    );

    regFile #(.XLEN(XLEN)) iRegs (
        .clk, .rstN,
        .raddrA1(exRsA1), .raddrA2(exRsA2), .raddrB1(exRsB1), .raddrB2(exRsB2),
        .weA(wbEnA), .weB(wbEnB), .waddrA(wbAddrA), .waddrB(wbAddrB),
        .wdataA(wbDataA), .wdataB(wbDataB),
        .rdataA1, .rdataA2, .rdataB1, .rdataB2
    );

    forwardUnit #(.XLEN(XLEN)) iFwd (
        .byp(iByp.sink),
        .raddrA1(exRsA1), .raddrA2(exRsA2), .raddrB1(exRsB1), .raddrB2(exRsB2),
        .rdataA1, .rdataA2, .rdataB1, .rdataB2,
        .opA1, .opA2, .opB1, .opB2
    );

    intAlu #(.XLEN(XLEN)) iAluA (.op(exOpA), .srcA(opA1), .srcB(opA2), .result(aluResA));
    intAlu #(.XLEN(XLEN)) iAluB (.op(exOpB), .srcA(opB1), .srcB(opB2), .result(aluResB));

endmodule

/* test/dualExec_chk.sv */
`timescale 1ns/1ps

module dualExecChk (
    input logic       clk,
    input logic       rstN,
    input logic       validA,
    input logic [4:0] rdA,
    input logic       validB,
    input logic [4:0] rdB,
    input logic       wbEnA,
    input logic [4:0] wbAddrA,
    input logic       wbEnB,
    input logic [4:0] wbAddrB
);

    int fails = 0;      // Assertion failures so far

    // Write-back enables stay low while reset is held
    resetQuiet: assert property (@(posedge clk) !rstN |-> (!wbEnA && !wbEnB))
        else begin
            $error("write-back enable high during reset");
            fails++;
        end

    // x0 writes are dropped at issue
    noZeroA: assert property (@(posedge clk) disable iff (!rstN) wbEnA |-> wbAddrA != '0)
        else begin
            $error("lane A write-back targets register zero");
            fails++;
        end
    noZeroB: assert property (@(posedge clk) disable iff (!rstN) wbEnB |-> wbAddrB != '0)
        else begin
            $error("lane B write-back targets register zero");
            fails++;
        end

    // Three edges from the sampling edge to visible write-back
    latencyA: assert property (@(posedge clk) disable iff (!rstN)
        (validA && rdA != '0) |-> ##3 (wbEnA && wbAddrA == $past(rdA, 3)))
        else begin
            $error("lane A write-back missing or wrong address three edges after issue");
            fails++;
        end
    latencyB: assert property (@(posedge clk) disable iff (!rstN)
        (validB && rdB != '0) |-> ##3 (wbEnB && wbAddrB == $past(rdB, 3)))
        else begin
            $error("lane B write-back missing or wrong address three edges after issue");
            fails++;
        end

endmodule

bind dualExecTop dualExecChk iChk (.*);

/* test/dualExecTb.sv */
`timescale 1ns/1ps

module dualExecTb;

    localparam int XLEN          = 32;
    localparam int RandomPairs   = 250;
    localparam int DirectedPairs = 52;     // Directed pairs, idles and drains
    localparam int PlannedPairs  = 8 + DirectedPairs + RandomPairs + 3;  // Reset, tests, drain

    logic                clk = 1'b0;
    logic                rstN;
    logic                validA, validB;
    dualIssuePkg::aluOpE opA, opB;
    logic [4:0]          rdA, rs1A, rs2A, rdB, rs1B, rs2B;
    logic                wbEnA, wbEnB;
    logic [4:0]          wbAddrA, wbAddrB;
    logic [XLEN-1:0]     wbDataA, wbDataB;

    logic [XLEN-1:0] refRegs [0:31];      // Architectural reference model
    logic [37:0]     expQA [$];           // {en, addr, data} per cycle
    logic [37:0]     expQB [$];
    int unsigned     seedState = 63824;
    int              errors    = 0;
    int              tests     = 0;
    int              testStart = 0;
    logic [4:0]      prevMulRd;

    dualExecTop #(.XLEN(XLEN)) i_dut (.*);

    always #2 clk = ~clk;

    initial begin
        #((PlannedPairs + 20) * 4);
        $display("Timeout: the tests did not complete in the expected time");
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic int unsigned nextRand();
        seedState = seedState * 32'd1664525 + 32'd1013904223;
        return seedState >> 8;
    endfunction

    function automatic logic [XLEN-1:0] refResult(dualIssuePkg::aluOpE op,
                                                  logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        case (op)
            dualIssuePkg::OpAdd: return a + b;
            dualIssuePkg::OpSub: return a - b;
            dualIssuePkg::OpAnd: return a & b;
            dualIssuePkg::OpOr:  return a | b;
            dualIssuePkg::OpXor: return a ^ b;
            dualIssuePkg::OpSll: return a << b[4:0];
            dualIssuePkg::OpSrl: return a >> b[4:0];
            dualIssuePkg::OpSlt: return ($signed(a) < $signed(b)) ? 1 : 0;
            dualIssuePkg::OpMul: return a * b;
            default:             return '0;
        endcase
    endfunction

    task automatic compareLane(string lane, logic [37:0] exp, logic en, logic [4:0] addr,
                               logic [XLEN-1:0] data);
        assert (en == exp[37]) else begin
            $display("Error: %0t wbEn%s expected %b actual %b", $time, lane, exp[37], en);
            errors++;
        end
        if (exp[37]) begin
            assert (addr == exp[36:32]) else begin
                $display("Error: %0t wbAddr%s expected %0d actual %0d", $time, lane,
                         exp[36:32], addr);
                errors++;
            end
            assert (data == exp[31:0]) else begin
                $display("Error: %0t wbData%s expected %h actual %h", $time, lane,
                         exp[31:0], data);
                errors++;
            end
        end
    endtask

    task automatic checkWb();
        logic [37:0] e;
        if (expQA.size() >= 3) begin   // Entry pushed three falling edges ago
            e = expQA.pop_front();
            compareLane("A", e, wbEnA, wbAddrA, wbDataA);
            e = expQB.pop_front();
            compareLane("B", e, wbEnB, wbAddrB, wbDataB);
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic issuePair(logic vA, dualIssuePkg::aluOpE oA, int dA, int aA1, int aA2,
                             logic vB, dualIssuePkg::aluOpE oB, int dB, int aB1, int aB2);
        logic [XLEN-1:0] resA;
        logic [XLEN-1:0] resB;
        checkWb();
        resA = refResult(oA, refRegs[aA1], refRegs[aA2]);   // Pre-pair state
        resB = refResult(oB, refRegs[aB1], refRegs[aB2]);
        expQA.push_back({vA && dA != 0, dA[4:0], resA});
        expQB.push_back({vB && dB != 0, dB[4:0], resB});
        if (vA && dA != 0) refRegs[dA] = resA;
        if (vB && dB != 0) refRegs[dB] = resB;              // B after A
        validA = vA;
        opA    = oA;
        rdA    = dA;
        rs1A   = aA1;
        rs2A   = aA2;
        validB = vB;
        opB    = oB;
        rdB    = dB;
        rs1B   = aB1;
        rs2B   = aB2;
        @(negedge clk);
    endtask

    task automatic idle(int n);
        repeat (n) issuePair(0, dualIssuePkg::OpAdd, 0, 0, 0, 0, dualIssuePkg::OpAdd, 0, 0, 0);
    endtask

    task automatic finishTest(string name);
        int total;
        idle(3);                       // Drain the pipeline
        total = errors + i_dut.iChk.fails;
        tests++;
        $display("Test %0d %s done, %0d errors", tests, name, total - testStart);
        testStart = total;
    endtask

    initial begin
        int unsigned r;
        int          rA1, rA2, rB1, rB2;
        dualIssuePkg::aluOpE oB;
        validA = 0;
        opA    = dualIssuePkg::OpAdd;
        rdA    = 0;
        rs1A   = 0;
        rs2A   = 0;
        validB = 0;
        opB    = dualIssuePkg::OpAdd;
        rdB    = 0;
        rs1B   = 0;
        rs2B   = 0;
        rstN = 1'b0;
        for (int i = 0; i < 32; i++) refRegs[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        // Backdoor preload since ALU ops on zeros only give zeros
        for (int i = 1; i < 16; i++) begin
            refRegs[i] = (32'h9E3779B9 * i) ^ (i << 27) ^ (i * 7);
            i_dut.iRegs.regs[i] = refRegs[i];
        end
        for (int j = 0; j < 8; j++)
            issuePair(1, dualIssuePkg::OpOr, 16 + j, j + 1, j + 8,
                      1, dualIssuePkg::OpXor, 24 + j, j + 2, 15 - j);
        finishTest("seeding");
        issuePair(1, dualIssuePkg::OpAdd, 16, 1, 2, 1, dualIssuePkg::OpXor, 17, 3, 4);
        issuePair(1, dualIssuePkg::OpSub, 18, 5, 6, 1, dualIssuePkg::OpSll, 19, 7, 8);
        issuePair(1, dualIssuePkg::OpSlt, 20, 9, 10, 1, dualIssuePkg::OpSrl, 21, 11, 12);
        issuePair(1, dualIssuePkg::OpAnd, 22, 13, 14, 1, dualIssuePkg::OpMul, 23, 15, 1);
        finishTest("independent pairs");
        issuePair(1, dualIssuePkg::OpAdd, 5, 1, 2, 1, dualIssuePkg::OpSub, 6, 3, 4);
        issuePair(1, dualIssuePkg::OpAnd, 7, 5, 6, 1, dualIssuePkg::OpOr, 8, 6, 5);
        issuePair(1, dualIssuePkg::OpXor, 9, 7, 8, 1, dualIssuePkg::OpAdd, 10, 8, 7);
        finishTest("back-to-back MEM forwarding");
        issuePair(1, dualIssuePkg::OpAdd, 11, 1, 2, 1, dualIssuePkg::OpXor, 11, 3, 4);
        issuePair(1, dualIssuePkg::OpSub, 12, 11, 1, 1, dualIssuePkg::OpOr, 13, 11, 11);
        issuePair(1, dualIssuePkg::OpAdd, 14, 3, 3, 1, dualIssuePkg::OpAdd, 14, 4, 4);
        idle(1);
        issuePair(1, dualIssuePkg::OpOr, 15, 14, 0, 1, dualIssuePkg::OpSll, 16, 14, 2);
        // x14 now from the register file
        issuePair(1, dualIssuePkg::OpXor, 17, 14, 1, 1, dualIssuePkg::OpAnd, 18, 14, 11);
        finishTest("same-pair destination");
        issuePair(1, dualIssuePkg::OpAdd, 17, 1, 2, 1, dualIssuePkg::OpSrl, 18, 3, 4);
        idle(1);
        issuePair(1, dualIssuePkg::OpSub, 19, 17, 18, 1, dualIssuePkg::OpSlt, 20, 18, 17);
        issuePair(1, dualIssuePkg::OpXor, 21, 5, 6, 1, dualIssuePkg::OpAdd, 22, 7, 8);
        idle(2);
        issuePair(1, dualIssuePkg::OpAnd, 23, 21, 22, 1, dualIssuePkg::OpOr, 24, 22, 21);
        finishTest("WB and register-file paths");
        issuePair(1, dualIssuePkg::OpAdd, 22, 1, 2, 1, dualIssuePkg::OpMul, 23, 3, 4);
        idle(1);
        issuePair(1, dualIssuePkg::OpAdd, 24, 23, 1, 1, dualIssuePkg::OpMul, 25, 23, 23);
        idle(2);
        issuePair(1, dualIssuePkg::OpXor, 26, 25, 23, 1, dualIssuePkg::OpMul, 27, 25, 26);
        finishTest("multiply through WB");
        prevMulRd = '0;
        repeat (RandomPairs) begin
            r   = nextRand();
            rA1 = nextRand() % 32;
            rA2 = nextRand() % 32;
            rB1 = nextRand() % 32;
            rB2 = nextRand() % 32;
            if (rA1 == prevMulRd) rA1 = 0;   // No reader right after a multiply
            if (rA2 == prevMulRd) rA2 = 0;
            if (rB1 == prevMulRd) rB1 = 0;
            if (rB2 == prevMulRd) rB2 = 0;
            oB = dualIssuePkg::aluOpE'(nextRand() % 9);
            issuePair(r[0] | r[1], dualIssuePkg::aluOpE'(nextRand() % 8), nextRand() % 32,
                      rA1, rA2, r[2] | r[3], oB, r[8:4], rB1, rB2);
            prevMulRd = (validB && oB == dualIssuePkg::OpMul) ? rdB : 5'd0;
        end
        finishTest("random streams");
        errors += i_dut.iChk.fails;
        $display("Tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* sim.f */
rtl/dualIssuePkg.sv
rtl/bypassIf.sv
rtl/regFile.sv
rtl/forwardUnit.sv
rtl/intAlu.sv
rtl/backendPipe.sv
rtl/dualExecTop.sv
test/dualExec_chk.sv
test/dualExecTb.sv
